/* Bender.yml */
package:
  name: wb_dma_writer

sources:
  - hw/dma_writer_pkg.sv
  - hw/ppfifo.sv
  - hw/ppfifo_data_sink.sv
  - hw/mem_2_ppfifo.sv
  - hw/wb_dma_writer.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/tb_wb_dma_writer.sv

/* files.f */
hw/dma_writer_pkg.sv
hw/ppfifo.sv
hw/ppfifo_data_sink.sv
hw/mem_2_ppfifo.sv
hw/wb_dma_writer.sv
tests/wb_mem_model.sv
tests/tb_wb_dma_writer.sv

/* hw/dma_writer_pkg.sv */
package dma_writer_pkg;

  // Register slave word addresses
  localparam logic [31:0] REG_CONTROL          = 32'd0;
  localparam logic [31:0] REG_STATUS           = 32'd1;
  localparam logic [31:0] REG_MEM_0_BASE       = 32'd2;
  localparam logic [31:0] REG_MEM_0_SIZE       = 32'd3;
  localparam logic [31:0] REG_MEM_1_BASE       = 32'd4;
  localparam logic [31:0] REG_MEM_1_SIZE       = 32'd5;
  localparam logic [31:0] REG_TOTAL_WRITE_SIZE = 32'd6;
  localparam logic [31:0] REG_SINK_COUNT       = 32'd7;
  localparam logic [31:0] REG_SINK_SUM         = 32'd8;

  // Bit positions in the control register
  localparam int CONTROL_ENABLE           = 0;
  localparam int CONTROL_ENABLE_INTERRUPT = 1;
  localparam int CONTROL_RESET            = 2;

  // Base registers come out of reset with these
  localparam logic [31:0] DEFAULT_MEM_0_BASE = 32'h0000_0000;
  localparam logic [31:0] DEFAULT_MEM_1_BASE = 32'h0000_1000;

  // Each FIFO half holds 2**PPFIFO_ADDR_W words
  localparam int PPFIFO_ADDR_W = 4;

  // Wishbone request, host to slave and master to memory
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // Wishbone response from memory
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

/* hw/mem_2_ppfifo.sv */
module mem_2_ppfifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_enable,
  input  logic [31:0]             i_mem_0_base,
  input  logic [31:0]             i_mem_0_size,
  input  logic                    i_mem_0_new_data,
  output logic [31:0]             o_mem_0_count,
  output logic                    o_mem_0_empty,
  input  logic [31:0]             i_mem_1_base,
  input  logic [31:0]             i_mem_1_size,
  input  logic                    i_mem_1_new_data,
  output logic [31:0]             o_mem_1_count,
  output logic                    o_mem_1_empty,
  output dma_writer_pkg::wb_req_t o_mem,
  input  dma_writer_pkg::wb_rsp_t i_mem,
  input  logic [1:0]              i_ppfifo_rdy,
  output logic [1:0]              o_ppfifo_act,
  input  logic [23:0]             i_ppfifo_size,
  output logic                    o_ppfifo_stb,
  output logic [31:0]             o_ppfifo_data
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_GRAB,
    S_ISSUE,
    S_WAIT,
    S_RELEASE
  } state_t;

  state_t      state;
  logic        r_sel;
  logic        r_req;
  logic [31:0] r_addr [2];
  logic [31:0] r_count [2];
  logic [1:0]  r_empty;
  logic [23:0] r_half_cnt;
  logic        w_ack;
  logic        w_last;

  assign o_mem_0_count = r_count[0];
  assign o_mem_1_count = r_count[1];
  assign o_mem_0_empty = r_empty[0];
  assign o_mem_1_empty = r_empty[1];

  // Word accepted by memory this cycle
  assign w_ack  = (state == S_WAIT) & i_mem.ack;
  // Region done or FIFO half full after this word
  assign w_last = (r_count[r_sel] == 32'd1) || (r_half_cnt + 24'd1 == i_ppfifo_size);

  // Read-only master driving all byte lanes
  always_comb begin
    o_mem     = '0;
    o_mem.cyc = r_req;
    o_mem.stb = r_req;
    o_mem.sel = 4'hF;
    o_mem.adr = r_addr[r_sel];
  end

  // Address and data path
  always_ff @(posedge clk) begin
    if (w_ack) begin
      r_addr[r_sel] <= r_addr[r_sel] + 32'd1;
      o_ppfifo_data <= i_mem.dat;
    end
    if (i_mem_0_new_data) begin
      r_addr[0] <= i_mem_0_base;
    end
    if (i_mem_1_new_data) begin
      r_addr[1] <= i_mem_1_base;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      r_sel        <= 1'b0;
      r_req        <= 1'b0;
      r_count[0]   <= 32'h0;
      r_count[1]   <= 32'h0;
      r_empty      <= 2'b11;
      r_half_cnt   <= 24'h0;
      o_ppfifo_act <= 2'b00;
      o_ppfifo_stb <= 1'b0;
    end else begin
      o_ppfifo_stb <= 1'b0;
      case (state)
        S_IDLE: begin
          // Region 0 first, then region 1
          if (i_enable && (r_empty != 2'b11)) begin
            r_sel <= r_empty[0];
            state <= S_GRAB;
          end
        end
        S_GRAB: begin
          if (!i_enable) begin
            state <= S_IDLE;
          end else if (i_ppfifo_rdy != 2'b00) begin
            o_ppfifo_act <= i_ppfifo_rdy[0] ? 2'b01 : 2'b10;
            r_half_cnt   <= 24'h0;
            state        <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          if (!i_enable) begin
            state <= S_RELEASE;
          end else begin
            r_req <= 1'b1;
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (i_mem.ack) begin
            r_req          <= 1'b0;
            o_ppfifo_stb   <= 1'b1;
            r_half_cnt     <= r_half_cnt + 24'd1;
            r_count[r_sel] <= r_count[r_sel] - 32'd1;
            if (r_count[r_sel] == 32'd1) begin
              r_empty[r_sel] <= 1'b1;
            end
            state <= w_last ? S_RELEASE : S_ISSUE;
          end
        end
        S_RELEASE: begin
          // Last strobe lands while act is still high
          o_ppfifo_act <= 2'b00;
          state        <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
      // New region setup overrides the running count
      if (i_mem_0_new_data) begin
        r_count[0] <= i_mem_0_size;
        r_empty[0] <= 1'b0;
      end
      if (i_mem_1_new_data) begin
        r_count[1] <= i_mem_1_size;
        r_empty[1] <= 1'b0;
      end
    end
  end

endmodule

/* hw/ppfifo.sv */
module ppfifo #(
  parameter int ADDR_W = dma_writer_pkg::PPFIFO_ADDR_W
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  i_wr_act,
  output logic [1:0]  o_wr_rdy,
  output logic [23:0] o_wr_size,
  input  logic        i_wr_stb,
  input  logic [31:0] i_wr_data,
  input  logic        i_rd_act,
  output logic        o_rd_rdy,
  output logic [23:0] o_rd_count,
  input  logic        i_rd_stb,
  output logic [31:0] o_rd_data
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [31:0]       mem [2][DEPTH];
  logic [ADDR_W:0]   r_fill [2];
  logic [1:0]        r_full;
  logic [1:0]        r_wr_act_d;
  logic              r_rd_act_d;
  logic              r_rd_sel;
  logic [ADDR_W-1:0] r_rd_ptr;
  logic              w_wr_half;
  logic              w_wr_en;
  logic [1:0]        w_wr_release;
  logic              w_rd_done;

  assign w_wr_half    = i_wr_act[1];
  assign w_wr_en      = i_wr_stb && (i_wr_act != 2'b00) &&
                        (r_fill[w_wr_half] != (ADDR_W + 1)'(DEPTH));
  // Falling activate hands a half over
  assign w_wr_release = r_wr_act_d & ~i_wr_act;
  assign w_rd_done    = r_rd_act_d & ~i_rd_act & r_full[r_rd_sel];

  // Not ready while owned or in the cycle after release
  assign o_wr_rdy   = ~r_full & ~i_wr_act & ~r_wr_act_d;
  assign o_wr_size  = 24'(DEPTH);
  assign o_rd_rdy   = r_full[r_rd_sel] & ~i_rd_act & ~r_rd_act_d;
  assign o_rd_count = 24'(r_fill[r_rd_sel]);
  assign o_rd_data  = mem[r_rd_sel][r_rd_ptr];

  always_ff @(posedge clk) begin
    if (w_wr_en) begin
      mem[w_wr_half][r_fill[w_wr_half][ADDR_W-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_fill[0]  <= '0;
      r_fill[1]  <= '0;
      r_full     <= 2'b00;
      r_wr_act_d <= 2'b00;
      r_rd_act_d <= 1'b0;
      r_rd_sel   <= 1'b0;
      r_rd_ptr   <= '0;
    end else begin
      r_wr_act_d <= i_wr_act;
      r_rd_act_d <= i_rd_act;
      if (w_wr_en) begin
        r_fill[w_wr_half] <= r_fill[w_wr_half] + 1'b1;
      end
      if (i_rd_stb && i_rd_act) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      // Reader finished, half is free and the other one is next
      if (w_rd_done) begin
        r_full[r_rd_sel] <= 1'b0;
        r_fill[r_rd_sel] <= '0;
        r_rd_ptr         <= '0;
        r_rd_sel         <= ~r_rd_sel;
      end
      for (int i = 0; i < 2; i++) begin
        if (w_wr_release[i] && (r_fill[i] != '0)) begin
          r_full[i] <= 1'b1;
          // Only jump the queue when nothing older waits
          if (!r_full[1-i]) begin
            r_rd_sel <= 1'(i);
          end
        end
      end
    end
  end

endmodule

/* hw/ppfifo_data_sink.sv */
module ppfifo_data_sink (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_rd_rdy,
  output logic        o_rd_act,
  input  logic [23:0] i_rd_count,
  output logic        o_rd_stb,
  input  logic [31:0] i_rd_data,
  output logic [31:0] o_word_count,
  output logic [31:0] o_word_sum
);

  // Words still to strobe from the active half
  logic [23:0] r_left;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_act     <= 1'b0;
      o_rd_stb     <= 1'b0;
      r_left       <= 24'h0;
      o_word_count <= 32'h0;
      o_word_sum   <= 32'h0;
    end else begin
      o_rd_stb <= 1'b0;
      if (!o_rd_act) begin
        if (i_rd_rdy) begin
          o_rd_act <= 1'b1;
          r_left   <= i_rd_count;
        end
      end else if (r_left != 24'h0) begin
        o_rd_stb <= 1'b1;
        r_left   <= r_left - 24'd1;
      end else begin
        // Last strobe is seen with act still high
        o_rd_act <= 1'b0;
      end
      if (o_rd_stb) begin
        o_word_count <= o_word_count + 32'd1;
        o_word_sum   <= o_word_sum + i_rd_data;
      end
    end
  end

endmodule

/* hw/wb_dma_writer.sv */
module wb_dma_writer (
  input  logic                    clk,
  input  logic                    rst,
  input  dma_writer_pkg::wb_req_t i_wbs,
  output logic                    o_wbs_ack,
  output logic [31:0]             o_wbs_dat,
  output logic                    o_wbs_int,
  output dma_writer_pkg::wb_req_t o_mem,
  input  dma_writer_pkg::wb_rsp_t i_mem
);

  logic [31:0] r_control;
  logic [31:0] r_mem_0_base;
  logic [31:0] r_mem_0_size;
  logic [31:0] r_mem_1_base;
  logic [31:0] r_mem_1_size;
  logic [31:0] r_total_size;
  logic [1:0]  r_new_data;

  logic        w_enable;
  logic        w_int_enable;
  logic        w_sub_rst;
  logic        w_access;
  logic [31:0] w_status;

  logic [31:0] w_mem_0_count;
  logic [31:0] w_mem_1_count;
  logic        w_mem_0_empty;
  logic        w_mem_1_empty;

  // Ping-pong write side
  logic [1:0]  w_wr_rdy;
  logic [1:0]  w_wr_act;
  logic [23:0] w_wr_size;
  logic        w_wr_stb;
  logic [31:0] w_wr_data;

  // Ping-pong read side
  logic        w_rd_rdy;
  logic        w_rd_act;
  logic [23:0] w_rd_count;
  logic        w_rd_stb;
  logic [31:0] w_rd_data;

  logic [31:0] w_sink_count;
  logic [31:0] w_sink_sum;

  assign w_enable     = r_control[dma_writer_pkg::CONTROL_ENABLE];
  assign w_int_enable = r_control[dma_writer_pkg::CONTROL_ENABLE_INTERRUPT];
  // Software reset of the datapath blocks
  assign w_sub_rst    = rst | r_control[dma_writer_pkg::CONTROL_RESET];
  // One access per strobe, the held strobe after ack is ignored
  assign w_access     = i_wbs.stb & i_wbs.cyc & ~o_wbs_ack;
  assign w_status     = {30'h0, w_mem_1_empty, w_mem_0_empty};

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wbs_ack    <= 1'b0;
      r_control    <= 32'h0;
      r_mem_0_base <= dma_writer_pkg::DEFAULT_MEM_0_BASE;
      r_mem_1_base <= dma_writer_pkg::DEFAULT_MEM_1_BASE;
      r_mem_0_size <= 32'h0;
      r_mem_1_size <= 32'h0;
      r_total_size <= 32'h0;
      r_new_data   <= 2'b00;
    end else begin
      r_new_data <= 2'b00;
      if (o_wbs_ack && !i_wbs.stb) begin
        o_wbs_ack <= 1'b0;
      end
      if (w_access) begin
        o_wbs_ack <= 1'b1;
        if (i_wbs.we) begin
          case (i_wbs.adr)
            dma_writer_pkg::REG_CONTROL:    r_control    <= i_wbs.dat;
            dma_writer_pkg::REG_MEM_0_BASE: r_mem_0_base <= i_wbs.dat;
            dma_writer_pkg::REG_MEM_1_BASE: r_mem_1_base <= i_wbs.dat;
            dma_writer_pkg::REG_MEM_0_SIZE: begin
              r_mem_0_size  <= i_wbs.dat;
              r_total_size  <= i_wbs.dat;
              r_new_data[0] <= (i_wbs.dat != 32'h0);
            end
            dma_writer_pkg::REG_MEM_1_SIZE: begin
              r_mem_1_size  <= i_wbs.dat;
              r_total_size  <= i_wbs.dat;
              r_new_data[1] <= (i_wbs.dat != 32'h0);
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  // Read data, sizes report what is left to fetch
  always_ff @(posedge clk) begin
    if (w_access && !i_wbs.we) begin
      case (i_wbs.adr)
        dma_writer_pkg::REG_CONTROL:          o_wbs_dat <= r_control;
        dma_writer_pkg::REG_STATUS:           o_wbs_dat <= w_status;
        dma_writer_pkg::REG_MEM_0_BASE:       o_wbs_dat <= r_mem_0_base;
        dma_writer_pkg::REG_MEM_0_SIZE:       o_wbs_dat <= w_mem_0_count;
        dma_writer_pkg::REG_MEM_1_BASE:       o_wbs_dat <= r_mem_1_base;
        dma_writer_pkg::REG_MEM_1_SIZE:       o_wbs_dat <= w_mem_1_count;
        dma_writer_pkg::REG_TOTAL_WRITE_SIZE: o_wbs_dat <= r_total_size;
        dma_writer_pkg::REG_SINK_COUNT:       o_wbs_dat <= w_sink_count;
        dma_writer_pkg::REG_SINK_SUM:         o_wbs_dat <= w_sink_sum;
        default:                              o_wbs_dat <= 32'h0;
      endcase
    end
  end

  // Interrupt drops on any strobe so a new one can follow
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wbs_int <= 1'b0;
    end else begin
      o_wbs_int <= w_enable & w_int_enable & ~i_wbs.stb &
                   (w_mem_0_empty | w_mem_1_empty);
    end
  end

  mem_2_ppfifo m2p (
    .clk              (clk),
    .rst              (w_sub_rst),
    .i_enable         (w_enable),
    .i_mem_0_base     (r_mem_0_base),
    .i_mem_0_size     (r_mem_0_size),
    .i_mem_0_new_data (r_new_data[0]),
    .o_mem_0_count    (w_mem_0_count),
    .o_mem_0_empty    (w_mem_0_empty),
    .i_mem_1_base     (r_mem_1_base),
    .i_mem_1_size     (r_mem_1_size),
    .i_mem_1_new_data (r_new_data[1]),
    .o_mem_1_count    (w_mem_1_count),
    .o_mem_1_empty    (w_mem_1_empty),
    .o_mem            (o_mem),
    .i_mem            (i_mem),
    .i_ppfifo_rdy     (w_wr_rdy),
    .o_ppfifo_act     (w_wr_act),
    .i_ppfifo_size    (w_wr_size),
    .o_ppfifo_stb     (w_wr_stb),
    .o_ppfifo_data    (w_wr_data)
  );

  ppfifo #(
    .ADDR_W (dma_writer_pkg::PPFIFO_ADDR_W)
  ) ping_pong (
    .clk        (clk),
    .rst        (w_sub_rst),
    .i_wr_act   (w_wr_act),
    .o_wr_rdy   (w_wr_rdy),
    .o_wr_size  (w_wr_size),
    .i_wr_stb   (w_wr_stb),
    .i_wr_data  (w_wr_data),
    .i_rd_act   (w_rd_act),
    .o_rd_rdy   (w_rd_rdy),
    .o_rd_count (w_rd_count),
    .i_rd_stb   (w_rd_stb),
    .o_rd_data  (w_rd_data)
  );

  ppfifo_data_sink sink (
    .clk          (clk),
    .rst          (w_sub_rst),
    .i_rd_rdy     (w_rd_rdy),
    .o_rd_act     (w_rd_act),
    .i_rd_count   (w_rd_count),
    .o_rd_stb     (w_rd_stb),
    .i_rd_data    (w_rd_data),
    .o_word_count (w_sink_count),
    .o_word_sum   (w_sink_sum)
  );

endmodule

/* tests/tb_wb_dma_writer.sv */
module tb_wb_dma_writer;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED        = 32'h1b31_d7d6;
  localparam logic [31:0] DATA_MASK   = 32'h5a5a_0000;
  localparam int          BUS_TIMEOUT = 50;
  localparam int          POLL_LIMIT  = 2000;
  localparam int          INT_TIMEOUT = 50;

  logic                    clk;
  logic                    rst;
  dma_writer_pkg::wb_req_t wbs;
  logic                    wbs_ack;
  logic [31:0]             wbs_dat;
  logic                    wbs_int;
  dma_writer_pkg::wb_req_t mem_req;
  dma_writer_pkg::wb_rsp_t mem_rsp;
  logic [31:0]             illegal_count;

  logic [31:0] rng_state;
  string       test_name;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  logic [31:0] rd;
  logic [31:0] base0;
  logic [31:0] base1;
  logic [31:0] size;
  logic [31:0] total_count;
  logic [31:0] total_sum;
  int          n;

  wb_dma_writer uut (
    .clk       (clk),
    .rst       (rst),
    .i_wbs     (wbs),
    .o_wbs_ack (wbs_ack),
    .o_wbs_dat (wbs_dat),
    .o_wbs_int (wbs_int),
    .o_mem     (mem_req),
    .i_mem     (mem_rsp)
  );

  wb_mem_model mem (
    .clk             (clk),
    .rst             (rst),
    .i_req           (mem_req),
    .o_rsp           (mem_rsp),
    .o_illegal_count (illegal_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Wrapping 32-bit sum of the memory model's words over a region
  function automatic logic [31:0] expected_sum(input logic [31:0] base, input logic [31:0] cnt);
    logic [31:0] sum;
    logic [31:0] i;
    sum = 32'h0;
    for (i = 0; i < cnt; i++) begin
      sum = sum + ((base + i) ^ DATA_MASK);
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("test %s: timed out waiting for %s", test_name, what);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test_name, errors - errors_at_start);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // Waits for ack, takes the read data, then ends the cycle
  task automatic finish_cycle(output logic [31:0] dat);
    int cnt;
    cnt = 0;
    while (!wbs_ack && cnt < BUS_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!wbs_ack) begin
      report_timeout("register slave ack");
    end
    dat     = wbs_dat;
    wbs.cyc = 1'b0;
    wbs.stb = 1'b0;
    wbs.we  = 1'b0;
    cnt     = 0;
    while (wbs_ack && cnt < BUS_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (wbs_ack) begin
      report_timeout("register slave ack to fall");
    end
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    @(negedge clk);
    wbs.cyc = 1'b1;
    wbs.stb = 1'b1;
    wbs.we  = 1'b1;
    wbs.sel = 4'hF;
    wbs.adr = adr;
    wbs.dat = dat;
    finish_cycle(unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wbs.cyc = 1'b1;
    wbs.stb = 1'b1;
    wbs.we  = 1'b0;
    wbs.sel = 4'hF;
    wbs.adr = adr;
    finish_cycle(dat);
  endtask

  // Polls status until all bits in mask are set
  task automatic wait_status(input logic [31:0] mask);
    logic [31:0] st;
    int          cnt;
    cnt = 0;
    st  = 32'h0;
    while (((st & mask) != mask) && cnt < POLL_LIMIT) begin
      wb_read(dma_writer_pkg::REG_STATUS, st);
      cnt++;
    end
    if ((st & mask) != mask) begin
      report_timeout("region empty flags");
    end
  endtask

  // The sink lags the read master so its counter is polled
  task automatic wait_sink_count(input logic [31:0] target);
    logic [31:0] cnt_val;
    int          cnt;
    cnt     = 0;
    cnt_val = 32'h0;
    while ((cnt_val != target) && cnt < POLL_LIMIT) begin
      wb_read(dma_writer_pkg::REG_SINK_COUNT, cnt_val);
      cnt++;
    end
    if (cnt_val != target) begin
      report_timeout("sink word count");
    end
  endtask

  initial begin
    wbs          = '0;
    rst          = 1'b1;
    rng_state    = SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    start_test("reset_values");
    check_value("o_wbs_int", 32'h0, {31'h0, wbs_int});
    check_value("memory cyc and stb", 32'h0, {30'h0, mem_req.cyc, mem_req.stb});
    wb_read(dma_writer_pkg::REG_CONTROL, rd);
    check_value("control", 32'h0, rd);
    wb_read(dma_writer_pkg::REG_MEM_0_BASE, rd);
    check_value("mem 0 base", dma_writer_pkg::DEFAULT_MEM_0_BASE, rd);
    wb_read(dma_writer_pkg::REG_MEM_1_BASE, rd);
    check_value("mem 1 base", dma_writer_pkg::DEFAULT_MEM_1_BASE, rd);
    wb_read(dma_writer_pkg::REG_STATUS, rd);
    check_value("status", 32'h3, rd);
    wb_read(dma_writer_pkg::REG_SINK_COUNT, rd);
    check_value("sink count", 32'h0, rd);
    wb_read(dma_writer_pkg::REG_SINK_SUM, rd);
    check_value("sink sum", 32'h0, rd);
    finish_test();

    start_test("register_access");
    base0 = next_random();
    base1 = next_random();
    wb_write(dma_writer_pkg::REG_MEM_0_BASE, base0);
    wb_write(dma_writer_pkg::REG_MEM_1_BASE, base1);
    wb_read(dma_writer_pkg::REG_MEM_0_BASE, rd);
    check_value("mem 0 base", base0, rd);
    wb_read(dma_writer_pkg::REG_MEM_1_BASE, rd);
    check_value("mem 1 base", base1, rd);
    size = (next_random() % 32'd40) + 32'd1;
    wb_write(dma_writer_pkg::REG_MEM_1_SIZE, size);
    wb_read(dma_writer_pkg::REG_TOTAL_WRITE_SIZE, rd);
    check_value("total write size", size, rd);
    // Nothing is fetched while disabled
    wb_read(dma_writer_pkg::REG_MEM_1_SIZE, rd);
    check_value("mem 1 remaining count", size, rd);
    wb_read(32'd9, rd);
    check_value("unmapped read", 32'h0, rd);
    // Engine is disabled so a control reset clears the pending region
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h4);
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h0);
    wb_read(dma_writer_pkg::REG_STATUS, rd);
    check_value("status after clear", 32'h3, rd);
    finish_test();

    start_test("single_region");
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h1);
    base0 = next_random();
    size  = (next_random() % 32'd40) + 32'd1;
    wb_write(dma_writer_pkg::REG_MEM_0_BASE, base0);
    wb_write(dma_writer_pkg::REG_MEM_0_SIZE, size);
    wait_status(32'h1);
    wb_read(dma_writer_pkg::REG_MEM_0_SIZE, rd);
    check_value("mem 0 remaining count", 32'h0, rd);
    total_count = size;
    total_sum   = expected_sum(base0, size);
    wait_sink_count(total_count);
    wb_read(dma_writer_pkg::REG_SINK_COUNT, rd);
    check_value("sink count", total_count, rd);
    wb_read(dma_writer_pkg::REG_SINK_SUM, rd);
    check_value("sink sum", total_sum, rd);
    check_value("illegal memory cycles", 32'h0, illegal_count);
    finish_test();

    start_test("both_regions");
    base0 = next_random();
    base1 = next_random();
    wb_write(dma_writer_pkg::REG_MEM_0_BASE, base0);
    wb_write(dma_writer_pkg::REG_MEM_0_SIZE, 32'd37);
    wb_write(dma_writer_pkg::REG_MEM_1_BASE, base1);
    wb_write(dma_writer_pkg::REG_MEM_1_SIZE, 32'd5);
    wait_status(32'h3);
    total_count = total_count + 32'd42;
    total_sum   = total_sum + expected_sum(base0, 32'd37) + expected_sum(base1, 32'd5);
    wait_sink_count(total_count);
    wb_read(dma_writer_pkg::REG_SINK_COUNT, rd);
    check_value("sink count", total_count, rd);
    wb_read(dma_writer_pkg::REG_SINK_SUM, rd);
    check_value("sink sum", total_sum, rd);
    check_value("illegal memory cycles", 32'h0, illegal_count);
    finish_test();

    start_test("interrupt");
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h3);
    n = 0;
    while (!wbs_int && n < INT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!wbs_int) begin
      report_timeout("interrupt");
    end
    // Hold a read strobe and look at the interrupt
    @(negedge clk);
    wbs.cyc = 1'b1;
    wbs.stb = 1'b1;
    wbs.we  = 1'b0;
    wbs.adr = dma_writer_pkg::REG_STATUS;
    @(negedge clk);
    check_value("o_wbs_int during strobe", 32'h0, {31'h0, wbs_int});
    finish_cycle(rd);
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h2);
    for (n = 0; n < 4; n++) begin
      @(negedge clk);
      check_value("o_wbs_int with enable cleared", 32'h0, {31'h0, wbs_int});
    end
    finish_test();

    start_test("control_reset");
    // Region 0 stays pending while the engine is disabled
    wb_write(dma_writer_pkg::REG_MEM_0_SIZE, 32'd8);
    wb_read(dma_writer_pkg::REG_STATUS, rd);
    check_value("status with region 0 pending", 32'h2, rd);
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h4);
    wb_write(dma_writer_pkg::REG_CONTROL, 32'h0);
    wb_read(dma_writer_pkg::REG_SINK_COUNT, rd);
    check_value("sink count", 32'h0, rd);
    wb_read(dma_writer_pkg::REG_SINK_SUM, rd);
    check_value("sink sum", 32'h0, rd);
    wb_read(dma_writer_pkg::REG_STATUS, rd);
    check_value("status", 32'h3, rd);
    finish_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tests/wb_mem_model.sv */
module wb_mem_model (
  input  logic                    clk,
  input  logic                    rst,
  input  dma_writer_pkg::wb_req_t i_req,
  output dma_writer_pkg::wb_rsp_t o_rsp,
  output logic [31:0]             o_illegal_count
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED      = 32'h1b31_d7d6;
  localparam logic [31:0] DATA_MASK = 32'h5a5a_0000;

  logic        r_ack     = 1'b0;
  logic [31:0] r_dat     = 32'h0;
  logic [31:0] r_rng     = SEED;
  logic [1:0]  r_wait    = 2'd0;
  logic [31:0] r_illegal = 32'h0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign o_rsp.ack       = r_ack;
  assign o_rsp.dat       = r_dat;
  assign o_illegal_count = r_illegal;

  // Responds on the falling edge with one ack pulse per read
  always @(negedge clk) begin
    if (rst) begin
      r_ack     <= 1'b0;
      r_dat     <= 32'h0;
      r_rng     <= SEED;
      r_wait    <= 2'd0;
      r_illegal <= 32'h0;
    end else begin
      r_ack <= 1'b0;
      if (i_req.cyc && i_req.stb && !r_ack) begin
        // Only full-word reads are legal here
        if (i_req.we || (i_req.sel != 4'hF)) begin
          r_illegal <= r_illegal + 32'd1;
        end
        if (r_wait == 2'd0) begin
          r_ack  <= 1'b1;
          r_dat  <= i_req.adr ^ DATA_MASK;
          r_rng  <= xorshift32(r_rng);
          // Next delay of 1 to 4 cycles
          r_wait <= 2'(xorshift32(r_rng));
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

endmodule
